// ==== Makefile ====
TOOL  := verilator
TOP   := tb_line_buffer
FLIST := sim.f
FLAGS := --binary --timing --assert -Wno-fatal -j 0
MDIR  := obj_dir

.PHONY: all run lint clean

all: run

run:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FLIST)
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation PASSED"

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(MDIR)

// ==== sim.f ====
verilog/lb_pkg.sv
verilog/line_sram.sv
verilog/line_writer.sv
verilog/ring_ctrl.sv
verilog/row_select.sv
verilog/window_reader.sv
verilog/bicubic_line_buffer.sv
test/tb_line_buffer.sv

// ==== test/tb_line_buffer.sv ====
// testbench that checks the bicubic line buffer windows against a clamped raster model.
`timescale 1ns/1ns
`default_nettype none

module tb_line_buffer import lb_pkg::*; ();

    localparam int W      = 16;
    localparam int H      = 8;
    localparam int PIXELS = W * H;
    localparam int COLS   = W - 3;                  // windows per row.
    localparam int TOTAL  = COLS * H;
    localparam int VW     = $bits(window_t);

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    pixel_t      in_data;
    logic        win_valid;
    logic        win_ready;
    window_t     win;
    logic        done;
    pixel_t      img [PIXELS];
    logic [31:0] rng;
    int          acc;                               // pixels accepted.
    int          nwin;                              // windows received.
    logic        held_valid;
    window_t     held_win;

    bicubic_line_buffer #(.IMG_WIDTH(W), .IMG_HEIGHT(H)) dut_i (
        .clk, .rst_n, .in_valid, .in_ready, .in_data, .win_valid, .win_ready, .win, .done
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (6 * 40 * PIXELS) @(posedge clk);    // six frames at most.
        $display("timeout: the DUT made no progress within the frame budget");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // lines r-1 to r+2 clamped to the image and columns c-3 to c.
    function automatic window_t expected_window(int r, int c);
        win_row_t rows [WIN_SIZE];
        int       l;
        for (int k = 0; k < WIN_SIZE; k++) begin
            l = (r + k - 1 < 0) ? 0 : (r + k - 1 > H - 1) ? H - 1 : r + k - 1;
            for (int j = 0; j < WIN_SIZE; j++) begin
                rows[k][j] = img[l * W + c - 3 + j];
            end
        end
        return {rows[0], rows[1], rows[2], rows[3]};
    endfunction

    task automatic check_value(string name, logic [VW-1:0] got, logic [VW-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        win_ready  = 1'b0;
        acc        = 0;
        nwin       = 0;
        held_valid = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    endtask

    // one cycle of source and sink at the falling edge.
    task automatic step(bit stall, bit gaps);
        bit rdy;
        bit vld;
        @(negedge clk);
        rng = xorshift32(rng);
        rdy = !stall || (rng[1:0] != 2'd0);
        vld = !gaps || (rng[4:2] != 3'd0);
        if (held_valid) begin
            check_value("win", VW'(win), VW'(held_win));        // stalled window holds.
        end
        if (acc == PIXELS) begin
            check_value("in_ready", VW'(in_ready), VW'(0));
        end
        win_ready = rdy;
        in_valid  = vld;
        in_data   = img[acc % PIXELS];
        if (vld && in_ready) begin
            acc++;
        end
        if (win_valid && rdy) begin
            check_value("win_count", VW'(nwin < TOTAL), VW'(1));
            check_value("win", VW'(win), VW'(expected_window(nwin / COLS, nwin % COLS + 3)));
            nwin++;
        end
        held_valid = win_valid && !rdy;
        held_win   = win;
    endtask

    // a stop count above zero leaves the frame unfinished.
    task automatic test_frame(bit stall, bit gaps, int stop);
        apply_reset();
        for (int i = 0; i < PIXELS; i++) begin
            rng    = xorshift32(rng);
            img[i] = pixel_t'(rng);
        end
        while (!done && (stop == 0 || nwin < stop)) begin
            step(stall, gaps);
        end
        if (stop == 0) begin
            check_value("win_count", VW'(nwin), VW'(TOTAL));    // done follows the last window.
            repeat (2 * W) step(stall, gaps);
            check_value("done", VW'(done), VW'(1));
            check_value("pixels_accepted", VW'(acc), VW'(PIXELS));
        end
    endtask

    task automatic test_reset_state();
        apply_reset();
        check_value("in_ready", VW'(in_ready), VW'(1));
        check_value("win_valid", VW'(win_valid), VW'(0));
        check_value("done", VW'(done), VW'(0));
    endtask

    task automatic test_mid_reset();
        test_frame(1'b0, 1'b0, TOTAL / 2);
        test_frame(1'b0, 1'b0, 0);
    endtask

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_data   = '0;
        win_ready = 1'b0;
        rng       = 32'h78fcdd7b;
        test_reset_state();
        test_frame(1'b0, 1'b0, 0);
        test_frame(1'b1, 1'b0, 0);
        test_frame(1'b0, 1'b1, 0);
        test_frame(1'b1, 1'b1, 0);
        test_mid_reset();
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/bicubic_line_buffer.sv ====
// top level of the bicubic line buffer with a ring of five line memories.
`timescale 1ns/1ns
`default_nettype none

module bicubic_line_buffer import lb_pkg::*; #(
    parameter int IMG_WIDTH  = 16,
    parameter int IMG_HEIGHT = 8
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    in_valid,
    output logic    in_ready,
    input  pixel_t  in_data,
    output logic    win_valid,
    input  logic    win_ready,
    output window_t win,
    output logic    done
);

    localparam int COL_W = $clog2(IMG_WIDTH);
    localparam int ROW_W = $clog2(IMG_HEIGHT);

    logic                   wr_open;
    logic                   wr_en;
    logic                   line_written;
    logic [COL_W-1:0]       wr_addr;
    logic [COL_W-1:0]       rd_addr;
    logic                   rd_cs;
    logic                   sweep_done;
    logic                   row_start;
    logic [ROW_W-1:0]       row;
    slot_t                  wr_slot;
    slot_t                  head_slot;
    pixel_t [NUM_LINES-1:0] mem_rdata;
    pixel_t [WIN_SIZE-1:0]  col_pixels;

    // the write slot takes the input side, every other memory follows the sweep
    for (genvar i = 0; i < NUM_LINES; i++) begin : g_mem
        logic sel;
        assign sel = (wr_slot == slot_t'(i));
        line_sram #(.DEPTH(IMG_WIDTH)) u_mem (
            .clk   (clk),
            .cs    (sel ? wr_en : rd_cs),
            .wr_en (sel && wr_en),
            .addr  (sel ? wr_addr : rd_addr),
            .wdata (in_data),
            .rdata (mem_rdata[i])
        );
    end

    line_writer #(.IMG_WIDTH(IMG_WIDTH)) u_writer (
        .clk, .rst_n, .in_valid, .in_ready, .wr_open, .wr_en, .wr_addr, .line_written
    );

    ring_ctrl #(.IMG_HEIGHT(IMG_HEIGHT)) u_ring (
        .clk, .rst_n, .line_written, .sweep_done, .wr_open, .wr_slot, .head_slot,
        .row, .row_start, .done
    );

    row_select #(.IMG_HEIGHT(IMG_HEIGHT)) u_rows (
        .head_slot, .row, .rdata(mem_rdata), .col_pixels
    );

    window_reader #(.IMG_WIDTH(IMG_WIDTH)) u_reader (
        .clk, .rst_n, .row_start, .col_pixels, .rd_addr, .rd_cs, .sweep_done,
        .win, .win_valid, .win_ready
    );

endmodule

`default_nettype wire

// ==== verilog/lb_pkg.sv ====
// shared pixel, window and ring types for the bicubic line buffer.
`default_nettype none

package lb_pkg;

    localparam int PIXEL_W   = 24;
    localparam int NUM_LINES = 5;   // line memories in the ring.
    localparam int WIN_SIZE  = 4;

    typedef logic [PIXEL_W-1:0] pixel_t;

    typedef logic [2:0] slot_t;     // index of a line memory, 0 to 4.

    // pixel 0 is the leftmost column
    typedef pixel_t [WIN_SIZE-1:0] win_row_t;

    typedef struct packed {
        win_row_t row0;             // top line.
        win_row_t row1;
        win_row_t row2;
        win_row_t row3;
    } window_t;

    typedef enum logic [1:0] {
        RING_FILL,                  // loading lines 0 to 2.
        RING_RUN,
        RING_DONE
    } ring_state_e;

    // step a slot index around the ring
    function automatic slot_t slot_add(slot_t s, int n);
        return slot_t'((int'(s) + n) % NUM_LINES);
    endfunction

endpackage

`default_nettype wire

// ==== verilog/line_sram.sv ====
// single-port line memory with a registered read under chip select.
`timescale 1ns/1ns
`default_nettype none

module line_sram import lb_pkg::*; #(
    parameter int DEPTH = 16
) (
    input  logic                     clk,
    input  logic                     cs,
    input  logic                     wr_en,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  pixel_t                   wdata,
    output pixel_t                   rdata
);

    pixel_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (cs) begin
            if (wr_en) begin
                mem[addr] <= wdata;
            end else begin
                rdata <= mem[addr];     // held until the next read.
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/line_writer.sv ====
// input side of the line buffer that writes one image line per opened slot.
`timescale 1ns/1ns
`default_nettype none

module line_writer #(
    parameter int IMG_WIDTH = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  logic                         wr_open,
    output logic                         wr_en,
    output logic [$clog2(IMG_WIDTH)-1:0] wr_addr,
    output logic                         line_written
);

    localparam int COL_W = $clog2(IMG_WIDTH);

    logic wr_full;

    assign in_ready     = !wr_full;
    assign wr_en        = in_valid && in_ready;     // memory written in the accept cycle.
    assign line_written = wr_en && (wr_addr == COL_W'(IMG_WIDTH - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_addr <= '0;
            wr_full <= 1'b0;                        // line 0 is open out of reset.
        end else begin
            if (line_written) begin
                wr_addr <= '0;
                wr_full <= 1'b1;
            end else if (wr_en) begin
                wr_addr <= wr_addr + COL_W'(1);
            end
            if (wr_open) begin
                wr_full <= 1'b0;
            end
        end
    end

    // the ring opens a new line only once the current one has filled
    a_open_full: assert property (@(posedge clk) disable iff (!rst_n)
        wr_open |-> wr_full)
        else $error("line opened before the previous one was full");

endmodule

`default_nettype wire

// ==== verilog/ring_ctrl.sv ====
// ring FSM that assigns line memories to window rows and to the next write.
`timescale 1ns/1ns
`default_nettype none

module ring_ctrl import lb_pkg::*; #(
    parameter int IMG_HEIGHT = 8
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          line_written,
    input  logic                          sweep_done,
    output logic                          wr_open,
    output slot_t                         wr_slot,
    output slot_t                         head_slot,
    output logic [$clog2(IMG_HEIGHT)-1:0] row,
    output logic                          row_start,
    output logic                          done
);

    localparam int ROW_W = $clog2(IMG_HEIGHT);

    ring_state_e state;
    logic        sweep_seen;
    logic        wr_seen;
    logic        wr_due;
    logic        row_adv;

    assign done    = (state == RING_DONE);
    assign wr_due  = (int'(row) + 3 < IMG_HEIGHT);              // line r+3 exists.
    assign row_adv = (state == RING_RUN) && (sweep_seen || sweep_done)
                  && (!wr_due || wr_seen || line_written);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= RING_FILL;
            row        <= '0;
            wr_slot    <= '0;
            head_slot  <= '0;
            wr_open    <= 1'b0;
            row_start  <= 1'b0;
            sweep_seen <= 1'b0;
            wr_seen    <= 1'b0;
        end else begin
            wr_open   <= 1'b0;
            row_start <= 1'b0;
            case (state)
                RING_FILL: begin
                    if (line_written) begin
                        wr_slot <= wr_slot + slot_t'(1);        // also counts the fill.
                        wr_open <= 1'b1;
                        if (wr_slot == slot_t'(2)) begin
                            state     <= RING_RUN;
                            row_start <= 1'b1;
                        end
                    end
                end
                RING_RUN: begin
                    if (row_adv) begin
                        sweep_seen <= 1'b0;
                        wr_seen    <= 1'b0;
                        if (row == ROW_W'(IMG_HEIGHT - 1)) begin
                            state <= RING_DONE;
                        end else begin
                            row       <= row + ROW_W'(1);
                            row_start <= 1'b1;
                            wr_slot   <= slot_add(wr_slot, 1);
                            wr_open   <= (int'(row) + 4 < IMG_HEIGHT);
                            if (row != '0) begin
                                head_slot <= slot_add(head_slot, 1);
                            end
                        end
                    end else begin
                        sweep_seen <= sweep_seen || sweep_done;
                        wr_seen    <= wr_seen || line_written;
                    end
                end
                default: ;
            endcase
        end
    end

    // row 0 reads only three distinct slots, so the write sits right after them
    a_slot_apart: assert property (@(posedge clk) disable iff (!rst_n)
        state == RING_RUN |-> wr_slot != head_slot
            && wr_slot != slot_add(head_slot, 1)
            && wr_slot != slot_add(head_slot, 2)
            && (row == '0 || wr_slot != slot_add(head_slot, 3)))
        else $error("write slot overlaps a window row");

endmodule

`default_nettype wire

// ==== verilog/row_select.sv ====
// maps the five memory outputs onto the four window rows with edge clamping.
`timescale 1ns/1ns
`default_nettype none

module row_select import lb_pkg::*; #(
    parameter int IMG_HEIGHT = 8
) (
    input  slot_t                         head_slot,
    input  logic [$clog2(IMG_HEIGHT)-1:0] row,
    input  pixel_t [NUM_LINES-1:0]        rdata,
    output pixel_t [WIN_SIZE-1:0]         col_pixels
);

    always_comb begin
        int base;
        int line;
        base = (row == '0) ? 0 : int'(row) - 1;                 // line held in head_slot.
        for (int k = 0; k < WIN_SIZE; k++) begin
            line = int'(row) + k - 1;
            if (line < 0) begin
                line = 0;
            end else if (line > IMG_HEIGHT - 1) begin
                line = IMG_HEIGHT - 1;                          // repeat the bottom line.
            end
            col_pixels[k] = rdata[slot_add(head_slot, line - base)];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/window_reader.sv ====
// column sweep that reads the ring and shifts 4x4 windows out to the scaler.
`timescale 1ns/1ns
`default_nettype none

module window_reader import lb_pkg::*; #(
    parameter int IMG_WIDTH = 16
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         row_start,
    input  pixel_t [WIN_SIZE-1:0]        col_pixels,
    output logic [$clog2(IMG_WIDTH)-1:0] rd_addr,
    output logic                         rd_cs,
    output logic                         sweep_done,
    output window_t                      win,
    output logic                         win_valid,
    input  logic                         win_ready
);

    localparam int COL_W = $clog2(IMG_WIDTH);
    localparam int CNT_W = $clog2(WIN_SIZE + 1);

    logic             sweeping;
    logic             pend;
    logic             shift;
    logic [CNT_W-1:0] loaded;

    function automatic win_row_t shift_row(win_row_t r, pixel_t px);
        return {px, r[WIN_SIZE-1:1]};
    endfunction

    assign shift      = pend && (!win_valid || win_ready);
    assign rd_cs      = sweeping && (!pend || shift);       // one read in flight at most.
    assign sweep_done = win_valid && win_ready && !sweeping && !pend;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sweeping  <= 1'b0;
            rd_addr   <= '0;
            pend      <= 1'b0;
            loaded    <= '0;
            win_valid <= 1'b0;
        end else begin
            if (row_start) begin
                sweeping <= 1'b1;
                rd_addr  <= '0;
                loaded   <= '0;
            end else if (rd_cs) begin
                rd_addr <= rd_addr + COL_W'(1);
                if (rd_addr == COL_W'(IMG_WIDTH - 1)) begin
                    sweeping <= 1'b0;
                end
            end
            pend <= rd_cs || (pend && !shift);              // memory data waits in rdata.
            if (shift) begin
                if (loaded != CNT_W'(WIN_SIZE)) begin
                    loaded <= loaded + CNT_W'(1);
                end
                win_valid <= (loaded >= CNT_W'(WIN_SIZE - 1));
            end else if (win_valid && win_ready) begin
                win_valid <= 1'b0;
            end
        end
    end

    // new column enters at the right edge.
    always_ff @(posedge clk) begin
        if (shift) begin
            win.row0 <= shift_row(win.row0, col_pixels[0]);
            win.row1 <= shift_row(win.row1, col_pixels[1]);
            win.row2 <= shift_row(win.row2, col_pixels[2]);
            win.row3 <= shift_row(win.row3, col_pixels[3]);
        end
    end

    a_win_hold: assert property (@(posedge clk) disable iff (!rst_n)
        win_valid && !win_ready |=> win_valid && $stable(win))
        else $error("window changed while stalled");

endmodule

`default_nettype wire
